// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int offset_bits = 3;
    localparam int index_bits = 4;
    localparam int tag_bits = 25;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] line_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0] tag_t;

    // zero is reserved for "no tag"
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        mshr_invalid = 2'd0,
        mshr_waiting = 2'd1,
        mshr_ready = 2'd2
    } mshr_state_e;

    typedef enum logic [1:0] {
        bus_none = 2'd0,
        bus_load = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    typedef struct packed {
        logic valid;
        logic is_store;
        mem_size_e size;
        addr_t address;
        word_t value;
    } cache_req_t;

    typedef struct packed {
        logic valid;
        logic is_store;
        addr_t address;
        word_t value;
    } cache_rsp_t;

    typedef struct packed {
        bus_cmd_e cmd;
        addr_t address;
        line_t data;
    } bus_req_t;

    // one outstanding miss
    typedef struct packed {
        logic is_store;
        mem_size_e size;
        addr_t address;
        word_t value;
        mem_tag_t mem_tag;
    } mshr_entry_t;

endpackage

`default_nettype wire

// File: src/lane_merge.sv
`timescale 1ns/1ns
`default_nettype none

module lane_merge import dcache_pkg::*; (
    input  line_t                  line,
    input  logic [offset_bits-1:0] offset,
    input  mem_size_e              size,
    input  word_t                  value,
    output line_t                  merged
);

    always_comb begin
        merged = line;
        case (size)
            size_byte: merged[{offset, 3'b000} +: 8] = value[7:0];
            // halves and words are aligned, low offset bits ignored
            size_half: merged[{offset[2:1], 4'b0000} +: 16] = value[15:0];
            default: merged[{offset[2], 5'b00000} +: 32] = value;
        endcase
    end

endmodule

`default_nettype wire

// File: src/lane_extract.sv
`timescale 1ns/1ns
`default_nettype none

module lane_extract import dcache_pkg::*; (
    input  line_t                  line,
    input  logic [offset_bits-1:0] offset,
    input  mem_size_e              size,
    output word_t                  value
);

    word_t half_line;
    word_t shifted;

    assign half_line = offset[2] ? line[63:32] : line[31:0];
    assign shifted = half_line >> {offset[1:0], 3'b000};

    always_comb begin
        case (size)
            size_byte: value = {24'b0, shifted[7:0]};
            size_half: value = {16'b0, shifted[15:0]};
            default: value = half_line;
        endcase
    end

endmodule

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/1ns
`default_nettype none

module line_store import dcache_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  cache_req_t req,
    input  line_t      store_line,
    input  logic       fill,
    input  addr_t      fill_address,
    input  line_t      fill_line,
    output logic       hit,
    output line_t      hit_line,
    output logic       victim_valid,
    output addr_t      victim_address,
    output line_t      victim_line
);

    localparam int num_sets = 1 << index_bits;

    tag_t tags [num_sets][2];
    line_t data [num_sets][2];
    logic [1:0] valid [num_sets];
    // most recently used way per set
    logic [num_sets-1:0] lru;

    index_t req_index;
    tag_t req_tag;
    index_t fill_index;
    tag_t fill_tag;
    logic [1:0] way_match;
    logic hit_way;
    logic victim_way;

    assign req_index = req.address[offset_bits +: index_bits];
    assign req_tag = req.address[offset_bits + index_bits +: tag_bits];
    assign fill_index = fill_address[offset_bits +: index_bits];
    assign fill_tag = fill_address[offset_bits + index_bits +: tag_bits];

    assign way_match[0] = valid[req_index][0] && (tags[req_index][0] == req_tag);
    assign way_match[1] = valid[req_index][1] && (tags[req_index][1] == req_tag);
    assign hit = req.valid && (|way_match);
    assign hit_way = way_match[1];
    assign hit_line = data[req_index][hit_way];

    assign victim_way = !lru[fill_index];
    assign victim_valid = fill && valid[fill_index][victim_way];
    assign victim_address = {tags[fill_index][victim_way], fill_index, {offset_bits{1'b0}}};
    assign victim_line = data[fill_index][victim_way];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= 2'b00;
            end
            lru <= '0;
        end else if (fill) begin
            valid[fill_index][victim_way] <= 1'b1;
            lru[fill_index] <= victim_way;
        end else if (hit) begin
            lru[req_index] <= hit_way;
        end
    end

    // fills and hits never share a cycle, busy keeps requests out
    always_ff @(posedge clock) begin
        if (fill) begin
            tags[fill_index][victim_way] <= fill_tag;
            data[fill_index][victim_way] <= fill_line;
        end else if (hit && req.is_store) begin
            data[req_index][hit_way] <= store_line;
        end
    end

endmodule

`default_nettype wire

// File: src/writeback_port.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_port import dcache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     miss_load,
    input  addr_t    miss_address,
    input  logic     victim_valid,
    input  addr_t    victim_address,
    input  line_t    victim_line,
    output bus_req_t bus,
    output logic     evict_pending
);

    logic pending;
    addr_t evict_address;
    line_t evict_line;

    assign evict_pending = pending;

    // miss loads go first, the eviction waits for an idle bus
    always_comb begin
        bus = '{cmd: bus_none, address: '0, data: '0};
        if (miss_load) begin
            bus.cmd = bus_load;
            bus.address = {miss_address[31:offset_bits], {offset_bits{1'b0}}};
        end else if (pending) begin
            bus.cmd = bus_store;
            bus.address = evict_address;
            bus.data = evict_line;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (victim_valid) begin
            pending <= 1'b1;
        end else if (!miss_load) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (victim_valid) begin
            evict_address <= victim_address;
            evict_line <= victim_line;
        end
    end

endmodule

`default_nettype wire

// File: src/mshr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mshr_ctrl import dcache_pkg::*; #(
    parameter int mshr_count = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  cache_req_t req,
    input  logic       hit,
    input  mem_tag_t   mem_response,
    input  mem_tag_t   mem_tag,
    input  line_t      mem_data,
    input  logic       evict_pending,
    output logic       miss_load,
    output logic       fill,
    output addr_t      fill_address,
    output logic       fill_store,
    output mem_size_e  fill_size,
    output word_t      fill_value,
    output cache_rsp_t miss_rsp,
    output logic       busy
);

    localparam int slot_bits = (mshr_count > 1) ? $clog2(mshr_count) : 1;

    mshr_entry_t entries [mshr_count];
    mshr_state_e state [mshr_count];
    line_t saved_line [mshr_count];

    logic miss;
    logic free_found;
    logic [slot_bits-1:0] free_slot;
    logic [mshr_count-1:0] tag_match;
    logic [slot_bits-1:0] fill_slot;
    logic done_found;
    logic [slot_bits-1:0] done_slot;
    word_t done_value;

    assign miss = req.valid && !hit;
    assign miss_load = miss;

    // walk downward so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_slot = '0;
        done_found = 1'b0;
        done_slot = '0;
        fill_slot = '0;
        for (int i = mshr_count - 1; i >= 0; i--) begin
            tag_match[i] = (state[i] == mshr_waiting) && (mem_tag != '0)
                && (entries[i].mem_tag == mem_tag);
            if (state[i] == mshr_invalid) begin
                free_found = 1'b1;
                free_slot = slot_bits'(i);
            end
            if (state[i] == mshr_ready) begin
                done_found = 1'b1;
                done_slot = slot_bits'(i);
            end
            if (tag_match[i]) begin
                fill_slot = slot_bits'(i);
            end
        end
    end

    assign fill = |tag_match;
    assign fill_address = entries[fill_slot].address;
    assign fill_store = entries[fill_slot].is_store;
    assign fill_size = entries[fill_slot].size;
    assign fill_value = entries[fill_slot].value;

    // a reply in flight would collide with a hit write
    assign busy = evict_pending || !free_found || fill;

    lane_extract u_miss_extract (
        .line(saved_line[done_slot]),
        .offset(entries[done_slot].address[offset_bits-1:0]),
        .size(entries[done_slot].size),
        .value(done_value)
    );

    always_comb begin
        miss_rsp.valid = done_found;
        miss_rsp.is_store = entries[done_slot].is_store;
        miss_rsp.address = entries[done_slot].address;
        miss_rsp.value = done_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mshr_count; i++) begin
                state[i] <= mshr_invalid;
            end
        end else begin
            for (int i = 0; i < mshr_count; i++) begin
                if (miss && free_found && free_slot == slot_bits'(i)) begin
                    state[i] <= mshr_waiting;
                end else if (tag_match[i]) begin
                    state[i] <= mshr_ready;
                end else if (done_found && done_slot == slot_bits'(i)) begin
                    state[i] <= mshr_invalid;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < mshr_count; i++) begin
            if (miss && free_found && free_slot == slot_bits'(i)) begin
                entries[i] <= '{
                    is_store: req.is_store,
                    size: req.size,
                    address: req.address,
                    value: req.value,
                    mem_tag: mem_response
                };
            end
            // raw refill, load lanes are read from here at completion
            if (tag_match[i]) begin
                saved_line[i] <= mem_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int mshr_count = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  cache_req_t req,
    input  mem_tag_t   mem_response,
    input  mem_tag_t   mem_tag,
    input  line_t      mem_data,
    output cache_rsp_t hit_rsp,
    output cache_rsp_t miss_rsp,
    output bus_req_t   bus,
    output logic       busy
);

    logic hit;
    line_t hit_line;
    line_t store_line;
    word_t hit_value;
    logic victim_valid;
    addr_t victim_address;
    line_t victim_line;
    logic miss_load;
    logic fill;
    addr_t fill_address;
    logic fill_store;
    mem_size_e fill_size;
    word_t fill_value;
    line_t fill_merged;
    line_t fill_line;
    logic evict_pending;

    // store misses land in the line together with the refill
    assign fill_line = fill_store ? fill_merged : mem_data;

    assign hit_rsp = '{
        valid: hit,
        is_store: req.is_store,
        address: req.address,
        value: hit_value
    };

    mshr_ctrl #(
        .mshr_count(mshr_count)
    ) u_mshr_ctrl (
        .clock(clock),
        .reset(reset),
        .req(req),
        .hit(hit),
        .mem_response(mem_response),
        .mem_tag(mem_tag),
        .mem_data(mem_data),
        .evict_pending(evict_pending),
        .miss_load(miss_load),
        .fill(fill),
        .fill_address(fill_address),
        .fill_store(fill_store),
        .fill_size(fill_size),
        .fill_value(fill_value),
        .miss_rsp(miss_rsp),
        .busy(busy)
    );

    line_store u_line_store (
        .clock(clock),
        .reset(reset),
        .req(req),
        .store_line(store_line),
        .fill(fill),
        .fill_address(fill_address),
        .fill_line(fill_line),
        .hit(hit),
        .hit_line(hit_line),
        .victim_valid(victim_valid),
        .victim_address(victim_address),
        .victim_line(victim_line)
    );

    lane_merge u_hit_merge (
        .line(hit_line),
        .offset(req.address[offset_bits-1:0]),
        .size(req.size),
        .value(req.value),
        .merged(store_line)
    );

    lane_merge u_fill_merge (
        .line(mem_data),
        .offset(fill_address[offset_bits-1:0]),
        .size(fill_size),
        .value(fill_value),
        .merged(fill_merged)
    );

    lane_extract u_hit_extract (
        .line(hit_line),
        .offset(req.address[offset_bits-1:0]),
        .size(req.size),
        .value(hit_value)
    );

    writeback_port u_writeback_port (
        .clock(clock),
        .reset(reset),
        .miss_load(miss_load),
        .miss_address(req.address),
        .victim_valid(victim_valid),
        .victim_address(victim_address),
        .victim_line(victim_line),
        .bus(bus),
        .evict_pending(evict_pending)
    );

endmodule

`default_nettype wire

// File: verif/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import dcache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  bus_req_t bus,
    output mem_tag_t mem_response,
    output mem_tag_t mem_tag,
    output line_t    mem_data
);

    typedef struct packed {
        addr_t address;
        mem_tag_t tag;
        logic [31:0] due;
    } reply_t;

    line_t lines [addr_t];
    reply_t replies [$];
    mem_tag_t next_tag;
    logic [31:0] cycle;
    logic [31:0] last_due;

    function automatic logic [7:0] fill_byte(input addr_t address);
        return address[7:0] ^ address[15:8] ^ {address[20:16], address[23:21]}
            ^ address[31:24] ^ 8'h5c;
    endfunction

    function automatic line_t read_line(input addr_t address);
        line_t result;
        if (lines.exists(address)) begin
            result = lines[address];
        end else begin
            for (int i = 0; i < 8; i++) begin
                result[i*8 +: 8] = fill_byte(address + addr_t'(i));
            end
        end
        return result;
    endfunction

    // 3 to 6 cycles, pushed back so that replies never share a cycle
    function automatic logic [31:0] reply_cycle(input logic [31:0] now,
                                                input logic [31:0] after,
                                                input mem_tag_t tag);
        logic [31:0] due;
        due = now + 32'd3 + 32'(tag[1:0]);
        if (due <= after) begin
            due = after + 32'd1;
        end
        return due;
    endfunction

    // tag offered in the same cycle as the bus load
    assign mem_response = (bus.cmd == bus_load) ? next_tag : '0;

    initial begin
        next_tag = 4'd1;
        cycle = '0;
        last_due = '0;
        mem_tag = '0;
        mem_data = '0;
    end

    always @(posedge clock) begin
        if (!reset) begin
            if (bus.cmd == bus_load) begin
                last_due = reply_cycle(cycle, last_due, next_tag);
                replies.push_back('{address: bus.address, tag: next_tag, due: last_due});
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end else if (bus.cmd == bus_store) begin
                lines[bus.address] = bus.data;
            end
        end
    end

    always @(negedge clock) begin
        cycle = cycle + 32'd1;
        mem_tag = '0;
        mem_data = '0;
        if (replies.size() > 0 && replies[0].due <= cycle) begin
            mem_tag = replies[0].tag;
            mem_data = read_line(replies[0].address);
            void'(replies.pop_front());
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int random_requests = 300;
    localparam int sweep_requests = 48;
    localparam int total_requests = random_requests + sweep_requests;
    localparam int cycle_limit = total_requests * 40 + 20;

    typedef struct packed {
        addr_t address;
        logic is_store;
        word_t expected;
    } pending_t;

    logic clock;
    logic reset;
    cache_req_t req;
    mem_tag_t mem_response;
    mem_tag_t mem_tag;
    line_t mem_data;
    cache_rsp_t hit_rsp;
    cache_rsp_t miss_rsp;
    bus_req_t bus;
    logic busy;

    logic [7:0] golden [addr_t];
    pending_t pending [$];
    logic [31:0] rng_state;
    int cycle_count = 0;
    int hit_count = 0;
    int miss_count = 0;
    int done_count = 0;

    dcache_top #(
        .mshr_count(4)
    ) u_dut (
        .clock(clock),
        .reset(reset),
        .req(req),
        .mem_response(mem_response),
        .mem_tag(mem_tag),
        .mem_data(mem_data),
        .hit_rsp(hit_rsp),
        .miss_rsp(miss_rsp),
        .bus(bus),
        .busy(busy)
    );

    tb_mem_model u_mem (
        .clock(clock),
        .reset(reset),
        .bus(bus),
        .mem_response(mem_response),
        .mem_tag(mem_tag),
        .mem_data(mem_data)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // untouched bytes follow the memory model pattern
    function automatic logic [7:0] fill_byte(input addr_t address);
        return address[7:0] ^ address[15:8] ^ {address[20:16], address[23:21]}
            ^ address[31:24] ^ 8'h5c;
    endfunction

    function automatic logic [7:0] golden_byte(input addr_t address);
        return golden.exists(address) ? golden[address] : fill_byte(address);
    endfunction

    function automatic line_t golden_line(input addr_t address);
        line_t result;
        for (int i = 0; i < 8; i++) begin
            result[i*8 +: 8] = golden_byte(address + addr_t'(i));
        end
        return result;
    endfunction

    // little endian and zero extended to 32 bits
    function automatic word_t ref_load(input addr_t address, input mem_size_e size);
        word_t value;
        value = {golden_byte(address + 32'd3), golden_byte(address + 32'd2),
                 golden_byte(address + 32'd1), golden_byte(address)};
        if (size == size_byte) begin
            value[31:8] = '0;
        end else if (size == size_half) begin
            value[31:16] = '0;
        end
        return value;
    endfunction

    task automatic write_golden(input addr_t address, input mem_size_e size, input word_t value);
        int count;
        count = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
        for (int i = 0; i < count; i++) begin
            golden[address + addr_t'(i)] = value[i*8 +: 8];
        end
    endtask

    function automatic logic line_pending(input addr_t address);
        foreach (pending[i]) begin
            if (pending[i].address[31:3] == address[31:3]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // 3 tags over 2 sets
    function automatic addr_t build_address(input int t, input int s, input logic [2:0] offset);
        tag_t tag;
        index_t index;
        case (t)
            0: tag = 25'h0000003;
            1: tag = 25'h0a5a5a5;
            default: tag = 25'h1f00c37;
        endcase
        index = (s == 0) ? 4'h2 : 4'hb;
        return {tag, index, offset};
    endfunction

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_with_error($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic send_request(input logic is_store, input mem_size_e size,
                                input addr_t address, input word_t value);
        @(negedge clock);
        #1;
        req.valid = 1'b0;
        while (busy || line_pending(address)) begin
            @(negedge clock);
            #1;
        end
        req = '{valid: 1'b1, is_store: is_store, size: size, address: address, value: value};
    endtask

    initial begin
        logic [31:0] r;
        mem_size_e size;
        logic [2:0] offset;
        rng_state = 32'hcc0;
        reset = 1'b1;
        req = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clock);
            #1;
            assert (!busy && !hit_rsp.valid && !miss_rsp.valid && bus.cmd == bus_none)
                else stop_with_error("outputs active while idle after reset");
        end
        for (int n = 0; n < random_requests; n++) begin
            r = next_random();
            size = (r[5:4] == 2'd3) ? size_word : mem_size_e'(r[5:4]);
            offset = r[8:6];
            if (size == size_half) begin
                offset[0] = 1'b0;
            end else if (size == size_word) begin
                offset[1:0] = 2'b00;
            end
            send_request(r[9], size, build_address(int'(r[12:10]) % 3, int'(r[13]), offset),
                         next_random());
        end
        // every byte of every line touched
        for (int t = 0; t < 3; t++) begin
            for (int s = 0; s < 2; s++) begin
                for (int o = 0; o < 8; o++) begin
                    send_request(1'b0, size_byte, build_address(t, s, 3'(o)), '0);
                end
            end
        end
        @(negedge clock);
        #1;
        req.valid = 1'b0;
        while (pending.size() > 0 || busy) begin
            @(negedge clock);
            #1;
        end
        repeat (2) @(posedge clock);
        #1;
        if (!busy && !miss_rsp.valid && bus.cmd == bus_none) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_error($sformatf("cache not idle after the last response %0d %0d %0d",
                                      hit_count, miss_count, done_count));
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_error("run exceeded its cycle limit, the cache stopped responding");
        end
    end

    always @(posedge clock) begin
        pending_t entry;
        int found;
        if (!reset) begin
            if (bus.cmd == bus_store) begin
                check_value("evict_offset", 64'd0, 64'(bus.address[2:0]));
                check_value("evict_data", golden_line(bus.address), bus.data);
            end
            if (miss_rsp.valid) begin
                found = -1;
                foreach (pending[i]) begin
                    if (pending[i].address == miss_rsp.address) begin
                        found = i;
                    end
                end
                assert (found >= 0)
                    else stop_with_error("miss response for an address with no miss outstanding");
                if (found >= 0) begin
                    entry = pending[found];
                    check_value("miss_kind", 64'(entry.is_store), 64'(miss_rsp.is_store));
                    if (!entry.is_store) begin
                        check_value("miss_load", 64'(entry.expected), 64'(miss_rsp.value));
                    end
                    pending.delete(found);
                    done_count++;
                end
            end
            if (req.valid && hit_rsp.valid) begin
                hit_count++;
                check_value("hit_address", 64'(req.address), 64'(hit_rsp.address));
                check_value("hit_kind", 64'(req.is_store), 64'(hit_rsp.is_store));
                assert (bus.cmd != bus_load) else stop_with_error("bus load issued on a hit");
                if (req.is_store) begin
                    write_golden(req.address, req.size, req.value);
                end else begin
                    check_value("hit_load", 64'(ref_load(req.address, req.size)),
                                64'(hit_rsp.value));
                end
            end else if (req.valid) begin
                miss_count++;
                check_value("miss_bus_cmd", 64'(bus_load), 64'(bus.cmd));
                check_value("miss_bus_address", 64'({req.address[31:3], 3'b000}),
                            64'(bus.address));
                pending.push_back('{address: req.address, is_store: req.is_store,
                                    expected: ref_load(req.address, req.size)});
                if (req.is_store) begin
                    write_golden(req.address, req.size, req.value);
                end
            end else begin
                assert (!hit_rsp.valid && bus.cmd != bus_load)
                    else stop_with_error("hit response or bus load without a request");
            end
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
src/dcache_pkg.sv
src/lane_merge.sv
src/lane_extract.sv
src/line_store.sv
src/writeback_port.sv
src/mshr_ctrl.sv
src/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_dcache
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
